// ==== verilog/bram_consts.svh ====
// depth and width macros for the block RAM, the request queue and the narrow bus
`ifndef BRAM_CONSTS_SVH
`define BRAM_CONSTS_SVH

// number of 64-bit words held by the RAM
`define BRAM_DEPTH_WORDS 256

// entries in the request queue between the wishbone slave and the sequencer
`define REQ_FIFO_DEPTH 4

// width of the multiplexed address/data path into the RAM
`define MBUS_WIDTH 32

// a memory word is two bus beats, low half first

`endif

// ==== verilog/bram_pkg.sv ====
// width typedefs, request and bus structs, and state enums of the memory subsystem
`include "bram_consts.svh"

package bram_pkg;

    typedef logic [31:0]                byte_addr_t;
    typedef logic [2*`MBUS_WIDTH-1:0]   mem_word_t;
    typedef logic [`MBUS_WIDTH-1:0]     bus_word_t;

    typedef struct packed {
        logic       write;
        byte_addr_t addr;
        mem_word_t  data;   // don't care for reads
    } mem_req_t;

    typedef struct packed {
        logic       valid;
        mem_word_t  data;
    } rd_rsp_t;

    typedef struct packed {
        logic       read_en;
        logic       write_en;
        logic       address_on;
        logic       data_on;
        bus_word_t  addr_data;
    } mbus_req_t;

    typedef struct packed {
        logic       resp;
        bus_word_t  rdata;
        logic       error;
    } mbus_rsp_t;

    typedef enum logic {wb_idle, wb_read_wait} wb_state_t;

    typedef enum logic [2:0] {mb_idle, mb_addr, mb_wr_lo, mb_wr_hi, mb_commit, mb_rd_lo,
        mb_rd_hi} mbus_state_t;

    typedef enum logic [2:0] {br_idle, br_address, br_data_lo, br_data_hi, br_fetch,
        br_read_hi, br_respond} bram_state_t;

endpackage

// ==== verilog/wb_req_capture.sv ====
// wishbone classic slave that posts writes into the request queue and returns read data
`timescale 1ns/100ps

module wb_req_capture import bram_pkg::*; (
    input  logic        itf,
    input  logic        reset,

    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  byte_addr_t  adr,
    input  mem_word_t   dat_w,
    output logic        ack,
    output mem_word_t   dat_r,

    input  logic        full,
    output logic        push,
    output mem_req_t    push_req,

    input  rd_rsp_t     rd_rsp
);

    wb_state_t state;
    logic      accept;

    // a cycle is taken only once, and only when the queue can hold it
    assign accept = cyc && stb && !ack && !full && (state == wb_idle);

    assign push = accept;

    always_comb begin
        push_req.write = we;
        push_req.addr  = adr;
        push_req.data  = dat_w;
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            state <= wb_idle;
            ack   <= 1'b0;
        end else begin
            ack <= 1'b0;   // ack is only ever a single-cycle pulse
            case (state)
                wb_idle: begin
                    if (accept) begin
                        if (we) begin
                            ack <= 1'b1;   // posted write, done as soon as it is queued
                        end else begin
                            state <= wb_read_wait;
                        end
                    end
                end
                wb_read_wait: begin
                    if (rd_rsp.valid) begin
                        ack   <= 1'b1;
                        state <= wb_idle;
                    end
                end
                default: begin
                    state <= wb_idle;
                end
            endcase
        end
    end

    // the read word is held until the master samples it with ack
    always_ff @(posedge itf) begin
        if ((state == wb_read_wait) && rd_rsp.valid) begin
            dat_r <= rd_rsp.data;
        end
    end

    // Note that the master keeps cyc and stb high while a read is outstanding,
    // so no second request can slip in before the read data returns.

endmodule

// ==== verilog/req_fifo.sv ====
// circular request queue with occupancy count, full and non-empty status
`timescale 1ns/100ps
`include "bram_consts.svh"

module req_fifo import bram_pkg::*; #(
    parameter int DEPTH = `REQ_FIFO_DEPTH
) (
    input  logic     itf,
    input  logic     reset,

    input  logic     push,
    input  mem_req_t push_req,
    output logic     full,

    input  logic     pop,
    output logic     not_empty,
    output mem_req_t head
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_req_t         entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign head      = entries[rd_ptr];

    always_ff @(posedge itf) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge itf) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
    end

endmodule

// ==== verilog/mbus_master.sv ====
// sequencer that drains the request queue and runs the two-beat multiplexed RAM bus
`timescale 1ns/100ps

module mbus_master import bram_pkg::*; (
    input  logic        itf,
    input  logic        reset,

    input  logic        not_empty,
    input  mem_req_t    head,
    output logic        pop,

    output mbus_req_t   bus_req,
    input  mbus_rsp_t   bus_rsp,

    output rd_rsp_t     rd_rsp
);

    mbus_state_t state;
    mem_req_t    req;      // request being worked on
    bus_word_t   rd_lo;    // low beat of a read, held until the high beat comes

    assign pop = (state == mb_idle) && not_empty;

    always_comb begin
        bus_req.read_en    = (state != mb_idle) && !req.write;
        bus_req.write_en   = (state != mb_idle) && req.write;
        bus_req.address_on = (state == mb_addr);
        bus_req.data_on    = (state == mb_wr_lo) || (state == mb_wr_hi);
        case (state)
            mb_addr:  bus_req.addr_data = req.addr;
            mb_wr_lo: bus_req.addr_data = req.data[`MBUS_WIDTH-1:0];
            mb_wr_hi: bus_req.addr_data = req.data[2*`MBUS_WIDTH-1:`MBUS_WIDTH];
            default:  bus_req.addr_data = '0;
        endcase
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            state        <= mb_idle;
            rd_rsp.valid <= 1'b0;
        end else begin
            rd_rsp.valid <= 1'b0;
            case (state)
                mb_idle: begin
                    if (not_empty) begin
                        state <= mb_addr;   // enable rises next cycle
                    end
                end
                mb_addr: begin
                    if (bus_rsp.resp) begin
                        state <= req.write ? mb_wr_lo : mb_rd_lo;
                    end
                end
                mb_wr_lo: begin
                    if (bus_rsp.resp) begin
                        state <= mb_wr_hi;
                    end
                end
                mb_wr_hi: begin
                    if (bus_rsp.resp) begin
                        state <= mb_commit;
                    end
                end
                mb_commit: begin
                    if (bus_rsp.resp) begin
                        state <= mb_idle;   // RAM has stored the word
                    end
                end
                mb_rd_lo: begin
                    if (bus_rsp.resp) begin
                        state <= mb_rd_hi;
                    end
                end
                mb_rd_hi: begin
                    if (bus_rsp.resp) begin
                        state        <= mb_idle;
                        rd_rsp.valid <= 1'b1;
                    end
                end
                default: begin
                    state <= mb_idle;
                end
            endcase
        end
    end

    always_ff @(posedge itf) begin
        if (pop) begin
            req <= head;
        end
        if ((state == mb_rd_lo) && bus_rsp.resp) begin
            rd_lo <= bus_rsp.rdata;
        end
        if ((state == mb_rd_hi) && bus_rsp.resp) begin
            rd_rsp.data <= {bus_rsp.rdata, rd_lo};
        end
    end

endmodule

// ==== verilog/fpga_bram.sv ====
// single-port 64-bit RAM behind a multiplexed 32-bit bus, with a sticky range error
`timescale 1ns/100ps
`include "bram_consts.svh"

module fpga_bram import bram_pkg::*; #(
    parameter int DEPTH_WORDS = `BRAM_DEPTH_WORDS
) (
    input  logic      itf,
    input  logic      reset,
    input  mbus_req_t bus_req,
    output mbus_rsp_t bus_rsp
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    mem_word_t        mem [DEPTH_WORDS];
    bram_state_t      state;
    bram_state_t      next_state;
    byte_addr_t       addr_q;
    logic             in_range_q;
    mem_word_t        wdata;
    bus_word_t        rdata;
    logic             resp;
    logic             error;
    bus_word_t        word_index;
    logic             addr_ok;
    logic [IDX_W-1:0] idx;

    assign word_index = bus_req.addr_data >> 3;   // low three bits pick a byte, ignored
    assign addr_ok    = (word_index < DEPTH_WORDS);
    assign idx        = addr_q[IDX_W+2:3];

    always_comb begin
        next_state = state;
        resp       = 1'b0;
        case (state)
            br_idle: begin
                if (bus_req.read_en || bus_req.write_en) begin
                    next_state = br_address;
                end
            end
            br_address: begin
                if (bus_req.address_on) begin
                    resp       = 1'b1;
                    next_state = bus_req.write_en ? br_data_lo : br_fetch;
                end
            end
            br_data_lo: begin
                if (bus_req.data_on) begin
                    resp       = 1'b1;
                    next_state = br_data_hi;
                end
            end
            br_data_hi: begin
                if (bus_req.data_on) begin
                    resp       = 1'b1;
                    next_state = br_respond;
                end
            end
            br_fetch:   next_state = br_read_hi;   // array access, no beat yet
            br_read_hi: begin
                resp       = 1'b1;   // low half is on the bus here
                next_state = br_respond;
            end
            br_respond: begin
                resp       = 1'b1;
                next_state = br_idle;
            end
            default:    next_state = br_idle;
        endcase
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            state <= br_idle;
            error <= 1'b0;
        end else begin
            state <= next_state;
            if ((state == br_address) && bus_req.address_on && !addr_ok) begin
                error <= 1'b1;   // stays up until the next reset
            end
        end
    end

    always_ff @(posedge itf) begin
        if ((state == br_address) && bus_req.address_on) begin
            addr_q     <= bus_req.addr_data;
            in_range_q <= addr_ok;
        end
        if ((state == br_data_lo) && bus_req.data_on) begin
            wdata[`MBUS_WIDTH-1:0] <= bus_req.addr_data;
        end
        if ((state == br_data_hi) && bus_req.data_on) begin
            wdata[2*`MBUS_WIDTH-1:`MBUS_WIDTH] <= bus_req.addr_data;
        end
        if (state == br_fetch) begin
            rdata <= in_range_q ? mem[idx][`MBUS_WIDTH-1:0] : '0;
        end else if (state == br_read_hi) begin
            rdata <= in_range_q ? mem[idx][2*`MBUS_WIDTH-1:`MBUS_WIDTH] : '0;
        end
    end

    // contents start at zero after reset, out-of-range writes are dropped
    always_ff @(posedge itf) begin
        if (reset) begin
            for (int i = 0; i < DEPTH_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if ((state == br_respond) && bus_req.write_en && in_range_q) begin
            mem[idx] <= wdata;
        end
    end

    always_comb begin
        bus_rsp.resp  = resp;
        bus_rsp.rdata = rdata;
        bus_rsp.error = error;
    end

endmodule

// ==== verilog/mem_subsystem.sv ====
// top level joining the wishbone slave, request queue, bus sequencer and block RAM
`timescale 1ns/100ps

module mem_subsystem import bram_pkg::*; (
    input  logic        itf,
    input  logic        reset,

    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  byte_addr_t  wb_adr,
    input  mem_word_t   wb_dat_w,
    output logic        wb_ack,
    output mem_word_t   wb_dat_r,

    output logic        mem_error
);

    logic      push;
    mem_req_t  push_req;
    logic      full;
    logic      pop;
    logic      not_empty;
    mem_req_t  head;
    rd_rsp_t   rd_rsp;
    mbus_req_t bus_req;
    mbus_rsp_t bus_rsp;

    wb_req_capture u_capture (
        .itf      (itf),
        .reset    (reset),
        .cyc      (wb_cyc),
        .stb      (wb_stb),
        .we       (wb_we),
        .adr      (wb_adr),
        .dat_w    (wb_dat_w),
        .ack      (wb_ack),
        .dat_r    (wb_dat_r),
        .full     (full),
        .push     (push),
        .push_req (push_req),
        .rd_rsp   (rd_rsp)
    );

    req_fifo u_fifo (
        .itf       (itf),
        .reset     (reset),
        .push      (push),
        .push_req  (push_req),
        .full      (full),
        .pop       (pop),
        .not_empty (not_empty),
        .head      (head)
    );

    mbus_master u_master (
        .itf       (itf),
        .reset     (reset),
        .not_empty (not_empty),
        .head      (head),
        .pop       (pop),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .rd_rsp    (rd_rsp)
    );

    fpga_bram u_bram (
        .itf     (itf),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    assign mem_error = bus_rsp.error;   // sticky flag straight from the RAM

endmodule

// ==== testbench/tb_clock_gen.sv ====
// clock and power-on reset source for the memory subsystem testbench
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,   // 100 ns clock period
    parameter int RESET_CYCLES = 2
) (
    output logic itf,
    output logic reset
);

    initial begin
        itf = 1'b0;
        forever begin
            #HALF_PERIOD itf = ~itf;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge itf);
        @(negedge itf);
        reset = 1'b0;   // released between rising edges
    end

endmodule

// ==== testbench/mem_subsystem_tb.sv ====
// memory subsystem testbench with wishbone tasks, lcg, shadow model, assertions and watchdog
`timescale 1ns/100ps
`include "bram_consts.svh"

module mem_subsystem_tb import bram_pkg::*; ();

    localparam int NUM_OPS     = 228;   // wishbone cycles issued by all tests together
    localparam int CYCLE_LIMIT = NUM_OPS * 6 * (`REQ_FIFO_DEPTH + 2);
    localparam int MIX_OPS     = 200;
    localparam int MIX_BASE    = 64;    // first word of the window hit by random traffic

    logic        itf;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    byte_addr_t  wb_adr;
    mem_word_t   wb_dat_w;
    logic        wb_ack;
    mem_word_t   wb_dat_r;
    logic        mem_error;

    mem_word_t   shadow [`BRAM_DEPTH_WORDS];
    logic [31:0] lcg_state;
    logic        oor_issued;
    int          data_errors;
    int          protocol_errors;
    int          cycles;

    tb_clock_gen clock_gen (
        .itf   (itf),
        .reset (reset)
    );

    mem_subsystem DUT (
        .itf       (itf),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .mem_error (mem_error)
    );

    // inputs change on the falling edge, so the protocol is sampled there too
    ack_in_cycle: assert property (@(negedge itf) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            protocol_errors++;
            $display("wb_ack was high outside an active wishbone cycle at %0t", $time);
        end

    ack_one_cycle: assert property (@(negedge itf) disable iff (reset)
        wb_ack |=> !wb_ack)
        else begin
            protocol_errors++;
            $display("wb_ack stayed high for two cycles at %0t", $time);
        end

    error_after_oor: assert property (@(negedge itf) disable iff (reset)
        mem_error |-> oor_issued)
        else begin
            protocol_errors++;
            $display("mem_error rose before any out-of-range access at %0t", $time);
        end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic byte_addr_t word_addr(input int idx, input logic [2:0] offset);
        return (byte_addr_t'(idx) << 3) | byte_addr_t'(offset);   // offset bits are ignored
    endfunction

    task automatic await_ack();
        @(negedge itf);
        while (!wb_ack) begin
            @(negedge itf);
        end
    endtask

    task automatic write_word(input int idx, input mem_word_t data, input logic [2:0] offset);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = word_addr(idx, offset);
        wb_dat_w = data;
        await_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (idx < `BRAM_DEPTH_WORDS) begin
            shadow[idx] = data;   // out-of-range writes never land
        end
    endtask

    task automatic expect_read(input int idx, input logic [2:0] offset);
        mem_word_t expected;
        mem_word_t got;
        expected = (idx < `BRAM_DEPTH_WORDS) ? shadow[idx] : '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b0;
        wb_adr   = word_addr(idx, offset);
        await_ack();
        got    = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        assert (got === expected)
        else begin
            data_errors++;
            $display("ERR wb_dat_r word %0h expected %h actual %h", idx, expected, got);
        end
    endtask

    task automatic verify_reset_state();
        assert (wb_ack === 1'b0)
        else begin
            data_errors++;
            $display("ERR wb_ack expected 0 actual %h", wb_ack);
        end
        assert (mem_error === 1'b0)
        else begin
            data_errors++;
            $display("ERR mem_error expected 0 actual %h", mem_error);
        end
        expect_read(0, 3'd0);
        expect_read(17, 3'd5);
        expect_read(128, 3'd7);
        expect_read(255, 3'd2);
    endtask

    task automatic single_word_roundtrip();
        write_word(5, 64'h0123_4567_89ab_cdef, 3'd0);
        expect_read(5, 3'd4);
        write_word(255, 64'hfedc_ba98_7654_3210, 3'd7);   // top word of the array
        expect_read(255, 3'd0);
    endtask

    task automatic burst_past_queue_depth();
        mem_word_t data;
        // eight writes over six words, so the first two words are overwritten
        for (int i = 0; i < 8; i++) begin
            data[63:32] = next_random();
            data[31:0]  = next_random();
            write_word(32 + (i % 6), data, 3'd0);
        end
        for (int i = 0; i < 6; i++) begin
            expect_read(32 + i, 3'd0);
        end
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        int          idx;
        mem_word_t   data;
        for (int n = 0; n < MIX_OPS; n++) begin
            r   = next_random();
            idx = MIX_BASE + int'(r[27:24]);
            if (r[31]) begin
                data[63:32] = next_random();
                data[31:0]  = next_random();
                write_word(idx, data, r[18:16]);
            end else begin
                expect_read(idx, r[18:16]);
            end
        end
    endtask

    task automatic out_of_range_access();
        oor_issued = 1'b1;
        write_word(`BRAM_DEPTH_WORDS, 64'hdead_beef_cafe_f00d, 3'd0);
        expect_read(261, 3'd3);   // word 261 would alias onto word 5, which holds data
        assert (mem_error === 1'b1)
        else begin
            data_errors++;
            $display("ERR mem_error expected 1 actual %h", mem_error);
        end
        expect_read(0, 3'd0);   // word 256 would alias onto word 0
        expect_read(5, 3'd0);
        expect_read(255, 3'd0);
        expect_read(MIX_BASE, 3'd0);
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge itf);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("Test failures found");
        $finish;
    end

    initial begin : stimulus
        data_errors     = 0;
        protocol_errors = 0;
        oor_issued      = 1'b0;
        lcg_state       = 32'd93;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = '0;
        wb_dat_w        = '0;
        for (int i = 0; i < `BRAM_DEPTH_WORDS; i++) begin
            shadow[i] = '0;   // RAM is cleared by reset
        end

        @(negedge reset);
        @(negedge itf);

        verify_reset_state();
        single_word_roundtrip();
        burst_past_queue_depth();
        random_traffic();
        out_of_range_access();

        $display("errors: data %0d, protocol %0d", data_errors, protocol_errors);
        if ((data_errors == 0) && (protocol_errors == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/bram_pkg.sv
verilog/wb_req_capture.sv
verilog/req_fifo.sv
verilog/mbus_master.sv
verilog/fpga_bram.sv
verilog/mem_subsystem.sv
testbench/tb_clock_gen.sv
testbench/mem_subsystem_tb.sv
